// File: verilog.f
verilog/ppu_bus_pkg.sv
verilog/ppu_video_pkg.sv
verilog/ppu_mode_seq.sv
verilog/ppu_bus_regs.sv
verilog/ppu_tile_fetcher.sv
verilog/ppu_pixel_fifo.sv
verilog/ppu_pixel_out.sv
verilog/ppu_top.sv
verif/ppu_assert.sv
verif/ppu_tb.sv

// File: Bender.yml
package:
  name: ppu

sources:
  - verilog/ppu_bus_pkg.sv
  - verilog/ppu_video_pkg.sv
  - verilog/ppu_mode_seq.sv
  - verilog/ppu_bus_regs.sv
  - verilog/ppu_tile_fetcher.sv
  - verilog/ppu_pixel_fifo.sv
  - verilog/ppu_pixel_out.sv
  - verilog/ppu_top.sv
  - target: test
    files:
      - verif/ppu_assert.sv
      - verif/ppu_tb.sv

// File: verif/ppu_tb.sv
`timescale 1ns/10ps

module ppu_tb
  import ppu_bus_pkg::*;
  import ppu_video_pkg::*;
();

  localparam int unsigned cycles_per_line = 120;
  localparam int unsigned oam_cycles      = 10;
  localparam int unsigned visible_lines   = 6;
  localparam int unsigned total_lines     = 9;
  localparam int unsigned screen_width    = 24;

  // ==============================
  // Run length
  // ==============================
  localparam int     render_cfgs  = 3;
  localparam int     total_frames = render_cfgs * 2 + 4;
  localparam int     bus_ops      = 20 * 16 + 8192 + 300 + render_cfgs * 80 + 260 + 220;
  localparam longint frame_ns     = longint'(total_lines) * cycles_per_line * 4;
  localparam longint watchdog_ns  = 2 * (total_frames * frame_ns + longint'(bus_ops) * 4 * 4);

  logic      clk;
  logic      reset;
  logic      wb_cyc;
  logic      wb_stb;
  logic      wb_we;
  bus_addr_t wb_adr;
  bus_data_t wb_dat_w;
  bus_data_t wb_dat_r;
  logic      wb_ack;
  logic      pix_valid;
  bus_data_t pix_x;
  bus_data_t pix_y;
  shade_t    pix_shade;
  ppu_mode_t lcd_mode;
  logic      frame_done;

  // Reference model state
  bus_data_t model_vram [8192];
  bus_data_t model_lcdc;
  bus_data_t model_scy;
  bus_data_t model_scx;
  bus_data_t model_lyc;
  bus_data_t model_bgp;
  int        ref_cyc;
  bus_data_t ref_line;
  logic      cur_on;
  int        pix_count;
  logic      hblank_seen;

  ppu_top #(
    .cycles_per_line(cycles_per_line),
    .oam_cycles     (oam_cycles),
    .visible_lines  (visible_lines),
    .total_lines    (total_lines),
    .screen_width   (screen_width)
  ) ppu_top_i (
    .clk       (clk),
    .reset     (reset),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack),
    .pix_valid (pix_valid),
    .pix_x     (pix_x),
    .pix_y     (pix_y),
    .pix_shade (pix_shade),
    .lcd_mode  (lcd_mode),
    .frame_done(frame_done)
  );

  always #2 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  // ==============================
  // Compare tasks
  // ==============================
  task automatic check_data(input string name, input bus_data_t act, input bus_data_t exp);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_shade(input string name, input shade_t act, input shade_t exp);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_x(input string name, input bus_data_t act, input bus_data_t exp);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0t: %s expected %0d got %0d", $time, name, exp, act));
    end
  endtask

  task automatic check_line(input string name, input bus_data_t act, input bus_data_t exp);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0t: %s expected %0d got %0d", $time, name, exp, act));
    end
  endtask

  task automatic check_mode(input string name, input ppu_mode_t act, input ppu_mode_t exp);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0t: %s expected %s got %s",
                          $time, name, exp.name(), act.name()));
    end
  endtask

  task automatic check_flag(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0t: %s expected %b got %b", $time, name, exp, act));
    end
  endtask

  // Background pixel from the model at screen position x, line
  function automatic shade_t expected_shade(input int x, input int line);
    int        row;
    int        col;
    int        map_addr;
    int        row_addr;
    int        bit_pos;
    bus_data_t tile;
    color_idx_t idx;
    row      = (line + model_scy) % 256;
    col      = (x + model_scx) % 256;
    map_addr = (model_lcdc[lcdc_map_hi] ? 16'h1C00 : 16'h1800) + (row / 8) * 32 + col / 8;
    tile     = model_vram[map_addr];
    row_addr = tile * 16 + (row % 8) * 2;
    bit_pos  = 7 - (col % 8);
    idx      = {model_vram[row_addr + 1][bit_pos], model_vram[row_addr][bit_pos]};
    if (!model_lcdc[lcdc_bg_on]) begin
      return 2'b00;
    end
    return shade_t'(model_bgp >> (2 * idx));
  endfunction

  function automatic bus_data_t expected_read(input bus_addr_t adr, input ppu_mode_t mode,
                                              input bus_data_t line);
    if (adr >= vram_base && adr <= vram_last) begin
      return (mode == mode_draw) ? open_bus_value : model_vram[adr - vram_base];
    end
    case (adr)
      lcdc_addr: return model_lcdc;
      stat_addr: return {5'b11111, line == model_lyc, mode};
      scy_addr:  return model_scy;
      scx_addr:  return model_scx;
      ly_addr:   return line;
      lyc_addr:  return model_lyc;
      bgp_addr:  return model_bgp;
      default:   return open_bus_value;
    endcase
  endfunction

  function automatic void model_write(input bus_addr_t adr, input bus_data_t d,
                                      input ppu_mode_t mode);
    if (adr >= vram_base && adr <= vram_last) begin
      if (mode != mode_draw) begin
        model_vram[adr - vram_base] = d;
      end
    end else begin
      case (adr)
        lcdc_addr: model_lcdc = d;
        scy_addr:  model_scy  = d;
        scx_addr:  model_scx  = d;
        lyc_addr:  model_lyc  = d;
        bgp_addr:  model_bgp  = d;
        default:   ;
      endcase
    end
  endfunction

  // One Wishbone classic cycle, mode taken when the request is first seen
  task automatic bus_access(input logic we, input bus_addr_t adr, input bus_data_t wdata,
                            output bus_data_t rdata, output ppu_mode_t req_mode,
                            output bus_data_t req_line);
    int waits;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdata;
    @(negedge clk);
    req_mode = lcd_mode;
    req_line = ref_line;
    if (we) begin
      model_write(adr, wdata, req_mode);
    end
    waits = 0;
    @(negedge clk);
    while (!wb_ack) begin
      waits++;
      if (waits > 4) begin
        abort_run($sformatf("No Wishbone ack for address %h at %0t", adr, $time));
      end
      @(negedge clk);
    end
    rdata = wb_dat_r;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic write_bus(input bus_addr_t adr, input bus_data_t d);
    bus_data_t rd;
    ppu_mode_t m;
    bus_data_t l;
    bus_access(1'b1, adr, d, rd, m, l);
  endtask

  task automatic read_check(input bus_addr_t adr);
    bus_data_t rd;
    ppu_mode_t m;
    bus_data_t l;
    bus_access(1'b0, adr, 8'h00, rd, m, l);
    check_data($sformatf("wb_dat_r[%h]", adr), rd, expected_read(adr, m, l));
  endtask

  task automatic wait_frames(input int n);
    int cycles;
    repeat (n) begin
      cycles = 0;
      @(negedge clk);
      while (!frame_done) begin
        cycles++;
        if (cycles > 2 * total_lines * cycles_per_line) begin
          abort_run("No frame_done pulse within two frame times");
        end
        @(negedge clk);
      end
    end
  endtask

  // Line and dot position as the sequencer should count it
  always @(posedge clk or posedge reset) begin
    if (reset) begin
      ref_cyc  <= 0;
      ref_line <= '0;
      cur_on   <= 1'b0;
    end else begin
      if (!cur_on) begin
        ref_cyc  <= 0;
        ref_line <= '0;
      end else if (ref_cyc == cycles_per_line - 1) begin
        ref_cyc  <= 0;
        ref_line <= (ref_line == total_lines - 1) ? 8'd0 : ref_line + 8'd1;
      end else begin
        ref_cyc <= ref_cyc + 1;
      end
      cur_on <= model_lcdc[lcdc_on];
    end
  end

  // ==============================
  // Output monitor
  // ==============================
  always @(negedge clk) begin
    if (!reset) begin
      if (ref_cyc == 0) begin
        pix_count   = 0;
        hblank_seen = 1'b0;
      end
      check_line("pix_y", pix_y, ref_line);
      if (!cur_on) begin
        check_mode("lcd_mode", lcd_mode, mode_hblank);
      end else if (ref_line >= visible_lines) begin
        check_mode("lcd_mode", lcd_mode, mode_vblank);
      end else if (ref_cyc < oam_cycles) begin
        check_mode("lcd_mode", lcd_mode, mode_oam);
      end else if (ref_cyc == oam_cycles) begin
        check_mode("lcd_mode", lcd_mode, mode_draw);
      end else if (lcd_mode == mode_hblank) begin
        hblank_seen = 1'b1;
      end else if (lcd_mode != mode_draw || hblank_seen) begin
        abort_run($sformatf("Bad mode %s after OAM scan at %0t", lcd_mode.name(), $time));
      end
      check_flag("frame_done", frame_done,
                 cur_on && ref_cyc == cycles_per_line - 1 && ref_line == total_lines - 1);
      if (pix_valid) begin
        if (lcd_mode != mode_draw || ref_line >= visible_lines || !cur_on) begin
          abort_run($sformatf("Pixel outside a visible drawing period at %0t", $time));
        end
        check_x("pix_x", pix_x, 8'(pix_count));
        check_shade("pix_shade", pix_shade, expected_shade(pix_count, ref_line));
        pix_count++;
      end
      if (cur_on && ref_line < visible_lines && ref_cyc == cycles_per_line - 1) begin
        check_x("pixels per line", 8'(pix_count), 8'(screen_width));
      end
    end
  end

  initial begin
    #(watchdog_ns * 1ns);
    abort_run("Watchdog timeout, the run did not finish in time");
  end

  // ==============================
  // Test sequence
  // ==============================
  initial begin
    bus_addr_t adr;
    bus_data_t d;
    bus_data_t map_sel;
    bus_addr_t written [$];
    int        sel;
    void'($urandom(32'h84b5));
    clk        = 1'b0;
    reset      = 1'b1;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_dat_w   = '0;
    model_lcdc = '0;
    model_scy  = '0;
    model_scx  = '0;
    model_lyc  = '0;
    model_bgp  = '0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;

    // Register file with the display off
    repeat (20) begin
      write_bus(lcdc_addr, 8'($urandom) & 8'h7F);
      write_bus(scy_addr, 8'($urandom));
      write_bus(scx_addr, 8'($urandom));
      write_bus(lyc_addr, 8'($urandom));
      write_bus(bgp_addr, 8'($urandom));
      write_bus(ly_addr, 8'($urandom));
      write_bus(stat_addr, 8'($urandom));
      read_check(lcdc_addr);
      read_check(stat_addr);
      read_check(scy_addr);
      read_check(scx_addr);
      read_check(ly_addr);
      read_check(lyc_addr);
      read_check(bgp_addr);
      adr = 16'($urandom) & 16'h7FFF;
      write_bus(adr, 8'($urandom));
      read_check(adr);
    end

    // Whole VRAM, then random readback
    for (int a = 0; a < 8192; a++) begin
      write_bus(vram_base + 16'(a), 8'($urandom));
    end
    repeat (300) begin
      read_check(vram_base + 16'($urandom % 8192));
    end

    // Background rendering over several settings, both maps covered
    for (int cfg = 0; cfg < render_cfgs; cfg++) begin
      repeat (64) begin
        write_bus(vram_base + 16'($urandom % 8192), 8'($urandom));
      end
      write_bus(scy_addr, 8'($urandom));
      write_bus(scx_addr, 8'($urandom));
      write_bus(bgp_addr, 8'($urandom));
      case (cfg)
        0:       map_sel = 8'h00;
        2:       map_sel = 8'h08;
        default: map_sel = 8'($urandom) & 8'h08;
      endcase
      d = 8'h80 | map_sel | ((cfg == 1) ? 8'h00 : 8'h01);
      write_bus(lcdc_addr, d);
      wait_frames(2);
      write_bus(lcdc_addr, d & 8'h7F);
    end

    // Blocking and status with the display on
    write_bus(lyc_addr, 8'($urandom % total_lines));
    write_bus(lcdc_addr, 8'h81);
    repeat (200) begin
      sel = $urandom % 4;
      adr = vram_base + 16'($urandom % 8192);
      case (sel)
        0: read_check(stat_addr);
        1: read_check(ly_addr);
        2: read_check(adr);
        default: begin
          write_bus(adr, 8'($urandom));
          written.push_back(adr);
        end
      endcase
    end
    wait_frames(1);
    write_bus(lcdc_addr, 8'h01);

    // Display off, dropped writes stay dropped
    foreach (written[i]) begin
      read_check(written[i]);
    end
    repeat (3 * cycles_per_line) @(negedge clk);
    read_check(ly_addr);
    read_check(stat_addr);

    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: verif/ppu_assert.sv
`timescale 1ns/10ps

module ppu_mode_seq_assert
  import ppu_bus_pkg::*;
  import ppu_video_pkg::*;
#(
  parameter int unsigned total_lines = 154
) (
  input logic      clk,
  input logic      reset,
  input ppu_mode_t mode,
  input bus_data_t ly,
  input logic      draw_start,
  input logic      line_done,
  input logic      frame_done,
  input logic      last_cycle
);

  draw_follows_start: assert property (@(posedge clk) disable iff (reset)
    draw_start |=> mode == mode_draw)
    else $error("draw_start not followed by mode_draw");

  line_done_in_draw: assert property (@(posedge clk) disable iff (reset)
    line_done |-> mode == mode_draw)
    else $error("line_done outside mode_draw");

  // Drawing must finish before the line wraps
  draw_before_end: assert property (@(posedge clk) disable iff (reset)
    mode == mode_draw |-> !last_cycle)
    else $error("mode_draw reached the end of the line");

  // Frame ends on the last line and the next frame starts at line 0
  frame_done_last_line: assert property (@(posedge clk) disable iff (reset)
    frame_done |-> ly == 8'(total_lines - 1) ##1 ly == 8'd0)
    else $error("frame_done not at the end of the last line");

endmodule

bind ppu_mode_seq ppu_mode_seq_assert #(
  .total_lines(total_lines)
) ppu_mode_seq_assert_i (
  .clk       (clk),
  .reset     (reset),
  .mode      (mode),
  .ly        (ly),
  .draw_start(draw_start),
  .line_done (line_done),
  .frame_done(frame_done),
  .last_cycle(last_cycle)
);

// File: verilog/ppu_top.sv
`timescale 1ns/10ps

module ppu_top
  import ppu_bus_pkg::*;
  import ppu_video_pkg::*;
#(
  parameter int unsigned cycles_per_line = 456,
  parameter int unsigned oam_cycles      = 80,
  parameter int unsigned visible_lines   = 144,
  parameter int unsigned total_lines     = 154,
  parameter int unsigned screen_width    = 160
) (
  input  logic      clk,
  input  logic      reset,
  input  logic      wb_cyc,
  input  logic      wb_stb,
  input  logic      wb_we,
  input  bus_addr_t wb_adr,
  input  bus_data_t wb_dat_w,
  output bus_data_t wb_dat_r,
  output logic      wb_ack,
  output logic      pix_valid,
  output bus_data_t pix_x,
  output bus_data_t pix_y,
  output shade_t    pix_shade,
  output ppu_mode_t lcd_mode,
  output logic      frame_done
);

  ppu_mode_t  mode;
  bus_data_t  ly;
  logic       draw_start;
  logic       line_done;
  bus_data_t  lcdc;
  bus_data_t  scy;
  bus_data_t  scx;
  bus_data_t  bgp;
  vram_addr_t fetch_addr;
  bus_data_t  fetch_data;
  logic       push;
  tile_row_t  push_row;
  logic       can_push;
  logic       empty;
  logic       pop;
  color_idx_t pop_px;

  assign pix_y    = ly;
  assign lcd_mode = mode;

  // ==============================
  // Control and CPU side
  // ==============================
  ppu_mode_seq #(
    .cycles_per_line(cycles_per_line),
    .oam_cycles     (oam_cycles),
    .visible_lines  (visible_lines),
    .total_lines    (total_lines)
  ) ppu_mode_seq_i (
    .clk       (clk),
    .reset     (reset),
    .lcdc      (lcdc),
    .line_done (line_done),
    .mode      (mode),
    .ly        (ly),
    .draw_start(draw_start),
    .frame_done(frame_done)
  );

  ppu_bus_regs ppu_bus_regs_i (
    .clk       (clk),
    .reset     (reset),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .mode      (mode),
    .ly        (ly),
    .fetch_addr(fetch_addr),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack),
    .fetch_data(fetch_data),
    .lcdc      (lcdc),
    .scy       (scy),
    .scx       (scx),
    .bgp       (bgp)
  );

  // ==============================
  // Background pixel pipeline
  // ==============================
  ppu_tile_fetcher ppu_tile_fetcher_i (
    .clk       (clk),
    .reset     (reset),
    .draw_start(draw_start),
    .mode      (mode),
    .lcdc      (lcdc),
    .scx       (scx),
    .scy       (scy),
    .ly        (ly),
    .fetch_data(fetch_data),
    .can_push  (can_push),
    .fetch_addr(fetch_addr),
    .push      (push),
    .push_row  (push_row)
  );

  ppu_pixel_fifo ppu_pixel_fifo_i (
    .clk     (clk),
    .reset   (reset),
    .clear   (draw_start),
    .push    (push),
    .pop     (pop),
    .push_row(push_row),
    .can_push(can_push),
    .empty   (empty),
    .pop_px  (pop_px)
  );

  ppu_pixel_out #(
    .screen_width(screen_width)
  ) ppu_pixel_out_i (
    .clk       (clk),
    .reset     (reset),
    .draw_start(draw_start),
    .empty     (empty),
    .pop_px    (pop_px),
    .scx       (scx),
    .lcdc      (lcdc),
    .bgp       (bgp),
    .pop       (pop),
    .pix_valid (pix_valid),
    .pix_x     (pix_x),
    .pix_shade (pix_shade),
    .line_done (line_done)
  );

endmodule

// File: verilog/ppu_pixel_out.sv
`timescale 1ns/10ps

module ppu_pixel_out
  import ppu_bus_pkg::*;
  import ppu_video_pkg::*;
#(
  parameter int unsigned screen_width = 160
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       draw_start,
  input  logic       empty,
  input  color_idx_t pop_px,
  input  bus_data_t  scx,
  input  bus_data_t  lcdc,
  input  bus_data_t  bgp,
  output logic       pop,
  output logic       pix_valid,
  output bus_data_t  pix_x,
  output shade_t     pix_shade,
  output logic       line_done
);

  logic      done;
  logic [2:0] discard;
  bus_data_t x_cnt;
  shade_t    shade;
  logic      emit;

  assign pop   = !empty && !done;
  // Fine scroll pixels are popped but never shown
  assign emit  = pop && (discard == 3'd0);
  assign shade = lcdc[lcdc_bg_on] ? shade_t'(bgp[{pop_px, 1'b0} +: 2]) : 2'b00;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      done      <= 1'b1;
      discard   <= '0;
      x_cnt     <= '0;
      pix_valid <= 1'b0;
      line_done <= 1'b0;
    end else begin
      pix_valid <= emit && !draw_start;
      line_done <= 1'b0;
      if (draw_start) begin
        done    <= 1'b0;
        discard <= scx[2:0];
        x_cnt   <= '0;
      end else if (pop) begin
        if (discard != 3'd0) begin
          discard <= discard - 3'd1;
        end else begin
          x_cnt <= x_cnt + 8'd1;
          if (x_cnt == 8'(screen_width - 1)) begin
            done      <= 1'b1;
            line_done <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (emit) begin
      pix_x     <= x_cnt;
      pix_shade <= shade;
    end
  end

endmodule

// File: verilog/ppu_pixel_fifo.sv
`timescale 1ns/10ps

module ppu_pixel_fifo
  import ppu_video_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       clear,
  input  logic       push,
  input  logic       pop,
  input  tile_row_t  push_row,
  output logic       can_push,
  output logic       empty,
  output color_idx_t pop_px
);

  localparam int unsigned depth = 16;
  localparam int unsigned ptr_w = $clog2(depth);

  color_idx_t       mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w:0]   count;

  // Room for a whole tile row
  assign can_push = count <= (ptr_w + 1)'(depth - tile_pixels);
  assign empty    = count == '0;
  assign pop_px   = mem[rd_ptr];

  // Eight consecutive slots per push, wrapping
  always_ff @(posedge clk) begin
    if (push) begin
      for (int i = 0; i < tile_pixels; i++) begin
        mem[ptr_w'(wr_ptr + i)] <= push_row[i];
      end
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + ptr_w'(tile_pixels);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + (push ? (ptr_w + 1)'(tile_pixels) : '0) - (pop ? 1'b1 : 1'b0);
    end
  end

endmodule

// File: verilog/ppu_tile_fetcher.sv
`timescale 1ns/10ps

module ppu_tile_fetcher
  import ppu_bus_pkg::*;
  import ppu_video_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       draw_start,
  input  ppu_mode_t  mode,
  input  bus_data_t  lcdc,
  input  bus_data_t  scx,
  input  bus_data_t  scy,
  input  bus_data_t  ly,
  input  bus_data_t  fetch_data,
  input  logic       can_push,
  output vram_addr_t fetch_addr,
  output logic       push,
  output tile_row_t  push_row
);

  typedef enum logic [1:0] {
    step_map,
    step_lo,
    step_hi,
    step_push
  } fetch_step_t;

  fetch_step_t step;
  logic        second;
  logic [4:0]  col;
  bus_data_t   tile_idx;
  bus_data_t   plane_lo;
  bus_data_t   plane_hi;
  bus_data_t   bg_row;
  logic        active;

  assign active = mode == mode_draw;
  assign bg_row = ly + scy;

  // ==============================
  // VRAM address
  // ==============================
  always_comb begin
    case (step)
      // Map at 0x1800 or 0x1C00, 32 x 32 entries
      step_map: fetch_addr = {2'b11, lcdc[lcdc_map_hi], bg_row[7:3], col};
      // 16 bytes per tile, two per row
      step_lo:  fetch_addr = {1'b0, tile_idx, bg_row[2:0], 1'b0};
      default:  fetch_addr = {1'b0, tile_idx, bg_row[2:0], 1'b1};
    endcase
  end

  assign push = active && (step == step_push) && can_push;

  // Bit 7 of each plane is the leftmost pixel
  always_comb begin
    for (int i = 0; i < tile_pixels; i++) begin
      push_row[i] = {plane_hi[7 - i], plane_lo[7 - i]};
    end
  end

  // Each read step: address out, then data back
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      step   <= step_map;
      second <= 1'b0;
      col    <= '0;
    end else if (draw_start) begin
      step   <= step_map;
      second <= 1'b0;
      col    <= scx[7:3];
    end else if (active) begin
      if (step == step_push) begin
        // Wait here under FIFO back-pressure
        if (can_push) begin
          step <= step_map;
          col  <= col + 5'd1;
        end
      end else if (second) begin
        second <= 1'b0;
        step   <= fetch_step_t'(step + 2'd1);
      end else begin
        second <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (active && second) begin
      case (step)
        step_map: tile_idx <= fetch_data;
        step_lo:  plane_lo <= fetch_data;
        step_hi:  plane_hi <= fetch_data;
        default:  ;
      endcase
    end
  end

endmodule

// File: verilog/ppu_bus_regs.sv
`timescale 1ns/10ps

module ppu_bus_regs
  import ppu_bus_pkg::*;
  import ppu_video_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       wb_cyc,
  input  logic       wb_stb,
  input  logic       wb_we,
  input  bus_addr_t  wb_adr,
  input  bus_data_t  wb_dat_w,
  input  ppu_mode_t  mode,
  input  bus_data_t  ly,
  input  vram_addr_t fetch_addr,
  output bus_data_t  wb_dat_r,
  output logic       wb_ack,
  output bus_data_t  fetch_data,
  output bus_data_t  lcdc,
  output bus_data_t  scy,
  output bus_data_t  scx,
  output bus_data_t  bgp
);

  localparam int unsigned vram_size = 2 ** $bits(vram_addr_t);

  bus_data_t  vram [vram_size];
  bus_data_t  lyc;
  bus_data_t  stat;
  bus_data_t  reg_rd;
  bus_data_t  reg_rd_q;
  bus_data_t  cpu_vram_q;
  vram_addr_t cpu_off;
  logic       req;
  logic       vram_hit;
  logic       blocked;
  logic       vram_we;
  logic       rd_vram_q;

  // New request only while no ack is outstanding
  assign req      = wb_cyc && wb_stb && !wb_ack;
  assign vram_hit = wb_adr inside {[vram_base:vram_last]};
  assign blocked  = mode == mode_draw;
  assign cpu_off  = vram_addr_t'(wb_adr - vram_base);
  assign vram_we  = req && wb_we && vram_hit && !blocked;

  // Coincidence flag and current mode, unused bits read as 1
  assign stat = {5'b11111, ly == lyc, mode};

  always_comb begin
    case (wb_adr)
      lcdc_addr: reg_rd = lcdc;
      stat_addr: reg_rd = stat;
      scy_addr:  reg_rd = scy;
      scx_addr:  reg_rd = scx;
      ly_addr:   reg_rd = ly;
      lyc_addr:  reg_rd = lyc;
      bgp_addr:  reg_rd = bgp;
      default:   reg_rd = open_bus_value;
    endcase
  end

  // ==============================
  // VRAM, CPU port and fetch port
  // ==============================
  always_ff @(posedge clk) begin
    if (vram_we) begin
      vram[cpu_off] <= wb_dat_w;
    end
    cpu_vram_q <= vram[cpu_off];
    fetch_data <= vram[fetch_addr];
  end

  // Register file and Wishbone handshake
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wb_ack    <= 1'b0;
      rd_vram_q <= 1'b0;
      reg_rd_q  <= open_bus_value;
      lcdc      <= '0;
      scy       <= '0;
      scx       <= '0;
      lyc       <= '0;
      bgp       <= '0;
    end else begin
      wb_ack <= req;
      if (req) begin
        rd_vram_q <= vram_hit && !blocked;
        reg_rd_q  <= reg_rd;
        if (wb_we) begin
          // LY and STAT are read only
          case (wb_adr)
            lcdc_addr: lcdc <= wb_dat_w;
            scy_addr:  scy  <= wb_dat_w;
            scx_addr:  scx  <= wb_dat_w;
            lyc_addr:  lyc  <= wb_dat_w;
            bgp_addr:  bgp  <= wb_dat_w;
            default:   ;
          endcase
        end
      end
    end
  end

  assign wb_dat_r = rd_vram_q ? cpu_vram_q : reg_rd_q;

endmodule

// File: verilog/ppu_mode_seq.sv
`timescale 1ns/10ps

module ppu_mode_seq
  import ppu_bus_pkg::*;
  import ppu_video_pkg::*;
#(
  parameter int unsigned cycles_per_line = 456,
  parameter int unsigned oam_cycles      = 80,
  parameter int unsigned visible_lines   = 144,
  parameter int unsigned total_lines     = 154
) (
  input  logic      clk,
  input  logic      reset,
  input  bus_data_t lcdc,
  input  logic      line_done,
  output ppu_mode_t mode,
  output bus_data_t ly,
  output logic      draw_start,
  output logic      frame_done
);

  localparam int unsigned cyc_w = $clog2(cycles_per_line);

  logic [cyc_w-1:0] cyc;
  bus_data_t        line;
  logic             draw_active;
  logic             display_on;
  logic             last_cycle;
  logic             visible;

  assign display_on = lcdc[lcdc_on];
  assign last_cycle = cyc == cyc_w'(cycles_per_line - 1);
  assign visible    = line < 8'(visible_lines);

  // Last OAM cycle of a visible line
  assign draw_start = display_on && visible && (cyc == cyc_w'(oam_cycles - 1));
  assign frame_done = display_on && last_cycle && (line == 8'(total_lines - 1));
  assign ly         = line;

  // ==============================
  // Mode decode
  // ==============================
  always_comb begin
    if (!display_on) begin
      mode = mode_hblank;
    end else if (!visible) begin
      mode = mode_vblank;
    end else if (cyc < cyc_w'(oam_cycles)) begin
      mode = mode_oam;
    end else if (draw_active) begin
      mode = mode_draw;
    end else begin
      mode = mode_hblank;
    end
  end

  // Dot and line counters, parked at zero while the LCD is off
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cyc         <= '0;
      line        <= '0;
      draw_active <= 1'b0;
    end else if (!display_on) begin
      cyc         <= '0;
      line        <= '0;
      draw_active <= 1'b0;
    end else begin
      if (last_cycle) begin
        cyc  <= '0;
        line <= (line == 8'(total_lines - 1)) ? 8'd0 : line + 8'd1;
      end else begin
        cyc <= cyc + 1'b1;
      end
      // Drawing length depends on the pixel pipeline, not on a count
      if (draw_start) begin
        draw_active <= 1'b1;
      end else if (line_done || last_cycle) begin
        draw_active <= 1'b0;
      end
    end
  end

endmodule

// File: verilog/ppu_video_pkg.sv
package ppu_video_pkg;

  // LCD mode as reported in STAT
  typedef enum logic [1:0] {
    mode_hblank = 2'd0,
    mode_vblank = 2'd1,
    mode_oam    = 2'd2,
    mode_draw   = 2'd3
  } ppu_mode_t;

  // Two bitplane bits of one tile pixel
  typedef logic [1:0] color_idx_t;

  // Grey level after the palette
  typedef logic [1:0] shade_t;

  // One decoded tile row, element 0 is the leftmost pixel
  typedef color_idx_t [7:0] tile_row_t;

  localparam int tile_pixels = 8;

endpackage

// File: verilog/ppu_bus_pkg.sv
package ppu_bus_pkg;

  // CPU side bus types
  typedef logic [15:0] bus_addr_t;
  typedef logic [7:0]  bus_data_t;
  typedef logic [12:0] vram_addr_t;

  // LCD register map
  localparam bus_addr_t lcdc_addr = 16'hFF40;
  localparam bus_addr_t stat_addr = 16'hFF41;
  localparam bus_addr_t scy_addr  = 16'hFF42;
  localparam bus_addr_t scx_addr  = 16'hFF43;
  localparam bus_addr_t ly_addr   = 16'hFF44;
  localparam bus_addr_t lyc_addr  = 16'hFF45;
  localparam bus_addr_t bgp_addr  = 16'hFF47;

  // Video RAM window
  localparam bus_addr_t vram_base = 16'h8000;
  localparam bus_addr_t vram_last = 16'h9FFF;

  // LCDC bits
  localparam int unsigned lcdc_on     = 7;
  // Selects the map at 0x9C00 instead of 0x9800
  localparam int unsigned lcdc_map_hi = 3;
  localparam int unsigned lcdc_bg_on  = 0;

  localparam bus_data_t open_bus_value = 8'hFF;

endpackage
